//--- logic/cps2_timing_pkg.sv
`default_nettype none

package cps2_timing_pkg;

    // Clock cycles of the 96 MHz clock between CPU enables, 16 MHz
    localparam int CPU_DIV_DEF = 6;

    // Clock cycles between pxl2_cen pulses, 16 MHz
    localparam int PXL_DIV_DEF = 6;

    // Enables of the CPU and pixel paths, all in the clk domain
    typedef struct packed {
        logic cpu_cen;
        // Half a CPU period after cpu_cen
        logic cpu_cenb;
        logic pxl2_cen;
        // Every second pxl2_cen
        logic pxl_cen;
    } cen_bus_t;

endpackage

`default_nettype wire

//--- logic/cps2_sdram_pkg.sv
`default_nettype none

package cps2_sdram_pkg;

    localparam int SD_AW = 23;

    // Word address of the SDRAM, one 32-bit word per step
    typedef logic [SD_AW-1:0] sd_addr_t;

    // Graphics take the full word, CPU and DMA one half of it
    typedef union packed {
        logic [31:0]      full;
        logic [1:0][15:0] half;   // half[1] is the upper half
    } sd_word_u;

    // Client address counts 16-bit half words
    typedef struct packed {
        logic        cs;
        logic        wr;
        logic [23:0] addr;
        logic [15:0] din;
        logic [1:0]  dsn;
    } client_req_t;

    typedef struct packed {
        logic     ok;
        sd_word_u data;
    } client_rsp_t;

    // Bank port to SDRAM controller
    typedef struct packed {
        sd_addr_t    addr;
        logic        rd;
        logic        wr;
        logic [15:0] din;
        logic [1:0]  din_m;
    } bank_cmd_t;

    typedef struct packed {
        logic ack;
        logic rdy;
    } bank_stat_t;

endpackage

`default_nettype wire

//--- logic/cps2_sys_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module cps2_sys_ctrl #(
    parameter int CPU_DIV = cps2_timing_pkg::CPU_DIV_DEF,
    parameter int PXL_DIV = cps2_timing_pkg::PXL_DIV_DEF
) (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire                       turbo,
    input  wire                       dma_busreq,
    input  wire                       cpu_busack,
    output logic                      sys_rst_n,
    output cps2_timing_pkg::cen_bus_t cen,
    output logic                      cpu_busreq,
    output logic                      dma_busack
);

    localparam int CW = $clog2(CPU_DIV);
    localparam int PW = $clog2(PXL_DIV);

    logic [1:0]    rst_sync;
    logic [CW-1:0] cpu_cnt;
    logic [PW-1:0] pxl_cnt;
    logic          pxl_half;
    logic          cpu_last;
    logic          pxl_last;

    // SDRAM side leaves reset on the second edge
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rst_sync <= 2'b00;
        end else begin
            rst_sync <= {rst_sync[0], 1'b1};
        end
    end

    assign sys_rst_n = rst_sync[1];

    assign cpu_last = cpu_cnt == CW'(CPU_DIV - 1);
    assign pxl_last = pxl_cnt == PW'(PXL_DIV - 1);

    always_ff @(posedge clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            cpu_cnt  <= '0;
            pxl_cnt  <= '0;
            pxl_half <= 1'b0;
            cen      <= '0;
        end else begin
            cpu_cnt <= cpu_last ? '0 : cpu_cnt + 1'b1;
            pxl_cnt <= pxl_last ? '0 : pxl_cnt + 1'b1;
            if (pxl_last) begin
                pxl_half <= ~pxl_half;
            end
            cen.cpu_cen  <= cpu_last;
            // 180 degree partner half a CPU period later
            cen.cpu_cenb <= cpu_cnt == CW'(CPU_DIV / 2 - 1);
            cen.pxl2_cen <= pxl_last;
            cen.pxl_cen  <= pxl_last & pxl_half;
        end
    end

    // Turbo lets video DMA run without halting the CPU
    assign cpu_busreq = dma_busreq & ~turbo;
    assign dma_busack = cpu_busack | turbo;

    a_cpu_cenb: assert property (@(posedge clk) disable iff (!sys_rst_n)
        cen.cpu_cen |-> !cen.cpu_cenb ##(CPU_DIV / 2) cen.cpu_cenb);

    a_pxl_cen: assert property (@(posedge clk) disable iff (!sys_rst_n)
        cen.pxl_cen |-> cen.pxl2_cen ##PXL_DIV (cen.pxl2_cen && !cen.pxl_cen));

endmodule

`default_nettype wire

//--- logic/cps2_bank_port.sv
`timescale 1ns/1ns
`default_nettype none

module cps2_bank_port #(
    parameter int NCLIENT  = 1,
    parameter bit WRITABLE = 1'b0
) (
    input  wire                                        clk,
    input  wire                                        rst_n,
    input  wire cps2_sdram_pkg::client_req_t [NCLIENT-1:0] req,
    input  wire cps2_sdram_pkg::bank_stat_t            stat,
    input  wire cps2_sdram_pkg::sd_word_u              data_read,
    output cps2_sdram_pkg::client_rsp_t [NCLIENT-1:0]  rsp,
    output cps2_sdram_pkg::bank_cmd_t                  cmd
);

    import cps2_sdram_pkg::*;

    localparam int SW = (NCLIENT > 1) ? $clog2(NCLIENT) : 1;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_CMD,
        ST_WAIT
    } state_t;

    state_t             state;
    logic [SW-1:0]      sel;
    logic [SW-1:0]      win;
    logic               any_cs;
    logic               wr_win;
    logic [NCLIENT-1:0] ok_q;
    logic               cmd_rd;
    logic               cmd_wr;
    sd_addr_t           cmd_addr;
    logic [15:0]        cmd_din;
    logic [1:0]         cmd_mask;
    sd_word_u           rd_word;

    // Fixed priority, index 0 wins. A client in its ok cycle is skipped
    always_comb begin
        any_cs = 1'b0;
        win    = '0;
        for (int i = NCLIENT - 1; i >= 0; i--) begin
            if (req[i].cs && !ok_q[i]) begin
                any_cs = 1'b1;
                win    = SW'(i);
            end
        end
        wr_win = req[win].wr & WRITABLE;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state  <= ST_IDLE;
            sel    <= '0;
            cmd_rd <= 1'b0;
            cmd_wr <= 1'b0;
            ok_q   <= '0;
        end else begin
            ok_q <= '0;
            case (state)
                ST_IDLE: begin
                    if (any_cs) begin
                        sel    <= win;
                        cmd_rd <= ~wr_win;
                        cmd_wr <= wr_win;
                        state  <= ST_CMD;
                    end
                end
                // Held until the controller takes it
                ST_CMD: begin
                    if (stat.ack) begin
                        cmd_rd <= 1'b0;
                        cmd_wr <= 1'b0;
                        state  <= ST_WAIT;
                    end
                end
                ST_WAIT: begin
                    if (stat.rdy) begin
                        ok_q[sel] <= 1'b1;
                        state     <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_IDLE && any_cs) begin
            cmd_addr <= req[win].addr[SD_AW:1];
            cmd_din  <= req[win].din;
            cmd_mask <= req[win].dsn;
        end
        if (state == ST_WAIT && stat.rdy) begin
            rd_word <= data_read;
        end
    end

    assign cmd = '{addr: cmd_addr, rd: cmd_rd, wr: cmd_wr, din: cmd_din, din_m: cmd_mask};

    // Both views go back, the client picks full or half
    always_comb begin
        for (int i = 0; i < NCLIENT; i++) begin
            rsp[i].ok   = ok_q[i];
            rsp[i].data = rd_word;
        end
    end

    a_cmd_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(cmd.rd && cmd.wr));

    a_one_ok: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(ok_q));

    a_read_only: assert property (@(posedge clk) disable iff (!rst_n)
        !WRITABLE |-> !cmd.wr);

endmodule

`default_nettype wire

//--- logic/cps2_core.sv
`timescale 1ns/1ns
`default_nettype none

module cps2_core #(
    parameter int CPU_DIV = cps2_timing_pkg::CPU_DIV_DEF,
    parameter int PXL_DIV = cps2_timing_pkg::PXL_DIV_DEF
) (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire                          turbo,
    input  wire                          dma_busreq,
    input  wire                          cpu_busack,
    input  wire cps2_sdram_pkg::client_req_t main_ram_req,
    input  wire cps2_sdram_pkg::client_req_t vram_dma_req,
    input  wire cps2_sdram_pkg::client_req_t main_rom_req,
    input  wire cps2_sdram_pkg::client_req_t rom0_req,
    input  wire cps2_sdram_pkg::client_req_t rom1_req,
    input  wire cps2_sdram_pkg::bank_stat_t  bank_stat [4],
    input  wire cps2_sdram_pkg::sd_word_u    data_read,
    output cps2_timing_pkg::cen_bus_t        cen,
    output logic                             cpu_busreq,
    output logic                             dma_busack,
    output cps2_sdram_pkg::client_rsp_t      main_ram_rsp,
    output cps2_sdram_pkg::client_rsp_t      vram_dma_rsp,
    output cps2_sdram_pkg::client_rsp_t      main_rom_rsp,
    output cps2_sdram_pkg::client_rsp_t      rom0_rsp,
    output cps2_sdram_pkg::client_rsp_t      rom1_rsp,
    output cps2_sdram_pkg::bank_cmd_t        bank_cmd [4]
);

    import cps2_sdram_pkg::*;

    logic              sys_rst_n;
    client_req_t [1:0] bank0_req;
    client_rsp_t [1:0] bank0_rsp;

    cps2_sys_ctrl #(
        .CPU_DIV    ( CPU_DIV       ),
        .PXL_DIV    ( PXL_DIV       )
    ) u_sys_ctrl (
        .clk        ( clk           ),
        .rst_n      ( rst_n         ),
        .turbo      ( turbo         ),
        .dma_busreq ( dma_busreq    ),
        .cpu_busack ( cpu_busack    ),
        .sys_rst_n  ( sys_rst_n     ),
        .cen        ( cen           ),
        .cpu_busreq ( cpu_busreq    ),
        .dma_busack ( dma_busack    )
    );

    // Bank 0 shares RAM and VRAM DMA, RAM first
    assign bank0_req = {vram_dma_req, main_ram_req};
    assign {vram_dma_rsp, main_ram_rsp} = bank0_rsp;

    cps2_bank_port #(.NCLIENT(2), .WRITABLE(1'b1)) u_bank0 (
        .clk        ( clk           ),
        .rst_n      ( sys_rst_n     ),
        .req        ( bank0_req     ),
        .stat       ( bank_stat[0]  ),
        .data_read  ( data_read     ),
        .rsp        ( bank0_rsp     ),
        .cmd        ( bank_cmd[0]   )
    );

    // Read only banks, one client each
    cps2_bank_port #(.NCLIENT(1), .WRITABLE(1'b0)) u_bank1 (
        .clk        ( clk           ),
        .rst_n      ( sys_rst_n     ),
        .req        ( main_rom_req  ),
        .stat       ( bank_stat[1]  ),
        .data_read  ( data_read     ),
        .rsp        ( main_rom_rsp  ),
        .cmd        ( bank_cmd[1]   )
    );

    cps2_bank_port #(.NCLIENT(1), .WRITABLE(1'b0)) u_bank2 (
        .clk        ( clk           ),
        .rst_n      ( sys_rst_n     ),
        .req        ( rom0_req      ),
        .stat       ( bank_stat[2]  ),
        .data_read  ( data_read     ),
        .rsp        ( rom0_rsp      ),
        .cmd        ( bank_cmd[2]   )
    );

    cps2_bank_port #(.NCLIENT(1), .WRITABLE(1'b0)) u_bank3 (
        .clk        ( clk           ),
        .rst_n      ( sys_rst_n     ),
        .req        ( rom1_req      ),
        .stat       ( bank_stat[3]  ),
        .data_read  ( data_read     ),
        .rsp        ( rom1_rsp      ),
        .cmd        ( bank_cmd[3]   )
    );

endmodule

`default_nettype wire

//--- tests/tb_sdram_model.sv
`timescale 1ns/1ns
`default_nettype none

module tb_sdram_model (
    input  wire                            clk,
    input  wire                            rst_n,
    input  wire cps2_sdram_pkg::bank_cmd_t cmd [4],
    output cps2_sdram_pkg::bank_stat_t     stat [4],
    output cps2_sdram_pkg::sd_word_u       data_read
);

    import cps2_sdram_pkg::*;

    integer   seed;
    int       phase [4];
    int       delay [4];
    sd_addr_t addr_q [4];
    logic     slot_taken;

    initial seed = 24;

    // Phase 0 idle, 1 counting down to rdy, 2 rdy given
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int b = 0; b < 4; b++) begin
                phase[b] <= 0;
                delay[b] <= 0;
                stat[b]  <= '0;
            end
            data_read <= '0;
        end else begin
            // Shared read bus, so one rdy per cycle
            slot_taken = 1'b0;
            for (int b = 0; b < 4; b++) begin
                stat[b] <= '0;
                case (phase[b])
                    0: begin
                        if (cmd[b].rd || cmd[b].wr) begin
                            addr_q[b]   <= cmd[b].addr;
                            delay[b]    <= 1 + int'($unsigned($random(seed)) % 4);
                            stat[b].ack <= 1'b1;
                            phase[b]    <= 1;
                        end
                    end
                    1: begin
                        if (delay[b] > 1) begin
                            delay[b] <= delay[b] - 1;
                        end else if (!slot_taken) begin
                            slot_taken     = 1'b1;
                            stat[b].rdy    <= 1'b1;
                            data_read.full <= {addr_q[b][15:0] ^ 16'hA5A5, addr_q[b][15:0]};
                            phase[b]       <= 2;
                        end
                    end
                    default: phase[b] <= 0;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

//--- tests/tb_cps2_core.sv
`timescale 1ns/1ns
`default_nettype none

module tb_cps2_core;

    import cps2_timing_pkg::*;
    import cps2_sdram_pkg::*;

    localparam int MAX_CYCLES = 4000;

    logic        clk;
    logic        rst_n;
    logic        turbo;
    logic        dma_busreq;
    logic        cpu_busack;
    // Clients 0 RAM, 1 VRAM DMA, 2 main ROM, 3 rom0, 4 rom1
    client_req_t req [5];
    client_rsp_t rsp [5];
    bank_cmd_t   bank_cmd [4];
    bank_stat_t  bank_stat [4];
    sd_word_u    data_read;
    cen_bus_t    cen;
    logic        cpu_busreq;
    logic        dma_busack;
    integer      seed;
    logic [31:0] rnd;
    int          cyc;
    int          err_count;
    int          test_errs;
    int          tests_run;
    logic [1:0]  rel_cnt;
    logic [7:0]  cpu_gap;
    logic [7:0]  pxl_gap;
    logic        cpu_seen;
    logic        pxl_seen;
    logic        pxl_prev;
    logic        ram_done;
    logic        wr_seen;
    logic [4:0]  ok_now;
    logic [4:0]  ok_prev;
    logic [16:0] quiet_bits;

    cps2_core #(.CPU_DIV(CPU_DIV_DEF), .PXL_DIV(PXL_DIV_DEF)) i_cps2_core (
        .clk(clk), .rst_n(rst_n), .turbo(turbo),
        .dma_busreq(dma_busreq), .cpu_busack(cpu_busack),
        .main_ram_req(req[0]), .vram_dma_req(req[1]), .main_rom_req(req[2]),
        .rom0_req(req[3]), .rom1_req(req[4]),
        .bank_stat(bank_stat), .data_read(data_read), .cen(cen),
        .cpu_busreq(cpu_busreq), .dma_busack(dma_busack),
        .main_ram_rsp(rsp[0]), .vram_dma_rsp(rsp[1]), .main_rom_rsp(rsp[2]),
        .rom0_rsp(rsp[3]), .rom1_rsp(rsp[4]), .bank_cmd(bank_cmd)
    );

    tb_sdram_model u_sdram (
        .clk(clk), .rst_n(rst_n), .cmd(bank_cmd), .stat(bank_stat), .data_read(data_read)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    // SDRAM word for a client half-word address
    function automatic logic [31:0] sd_word(input logic [23:0] a);
        logic [15:0] lo;
        lo = a[16:1];
        return {lo ^ 16'hA5A5, lo};
    endfunction

    function automatic logic [15:0] sd_half(input logic [23:0] a);
        logic [31:0] w;
        w = sd_word(a);
        return a[0] ? w[31:16] : w[15:0];
    endfunction

    task automatic show_mismatch(input string name, input logic [63:0] exp,
                                 input logic [63:0] act);
        $display("FAILED %s expected 0x%h got 0x%h", name, exp, act);
        err_count++;
    endtask

    task automatic note_failure(input string what);
        $display("%s", what);
        err_count++;
    endtask

    task automatic close_test(input string name);
        tests_run++;
        $display("Test %0d, %s: %0d errors", tests_run, name, err_count - test_errs);
        test_errs = err_count;
    endtask

    // Hold the request until ok and drop it on the edge that sees ok
    task automatic access(input int id, input logic is_wr, input logic [23:0] a,
                          input logic [15:0] d, input logic [1:0] dsn);
        @(posedge clk);
        req[id] <= '{cs: 1'b1, wr: is_wr, addr: a, din: d, dsn: dsn};
        do begin
            @(posedge clk);
        end while (!rsp[id].ok);
        req[id].cs <= 1'b0;
    endtask

    assign ok_now = {rsp[4].ok, rsp[3].ok, rsp[2].ok, rsp[1].ok, rsp[0].ok};
    assign quiet_bits = {cen,
        bank_cmd[3].rd, bank_cmd[2].rd, bank_cmd[1].rd, bank_cmd[0].rd,
        bank_cmd[3].wr, bank_cmd[2].wr, bank_cmd[1].wr, bank_cmd[0].wr, ok_now};

    // rel_cnt mirrors the two-edge release of the SDRAM side reset
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rel_cnt  <= 2'd0;
            cpu_gap  <= 8'd0;
            pxl_gap  <= 8'd0;
            cpu_seen <= 1'b0;
            pxl_seen <= 1'b0;
            pxl_prev <= 1'b0;
            ram_done <= 1'b0;
            wr_seen  <= 1'b0;
            ok_prev  <= 5'd0;
        end else begin
            if (rel_cnt != 2'd2) begin
                rel_cnt <= rel_cnt + 2'd1;
            end
            cpu_gap <= cen.cpu_cen ? 8'd1 : cpu_gap + 8'd1;
            pxl_gap <= cen.pxl2_cen ? 8'd1 : pxl_gap + 8'd1;
            if (cen.cpu_cen) begin
                cpu_seen <= 1'b1;
            end
            if (cen.pxl2_cen) begin
                pxl_seen <= 1'b1;
                pxl_prev <= cen.pxl_cen;
            end
            if (rsp[0].ok) begin
                ram_done <= 1'b1;
            end else if (rsp[1].ok) begin
                ram_done <= 1'b0;
            end
            if (bank_cmd[0].wr) begin
                wr_seen <= 1'b1;
            end
            ok_prev <= ok_now;
        end
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc == MAX_CYCLES) begin
            $display("Timeout, run did not end within %0d cycles", MAX_CYCLES);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    a_quiet: assert property (@(posedge clk) cyc > 2 && rel_cnt != 2'd2 |-> quiet_bits == 17'h0)
        else show_mismatch("enables/rd/wr/ok in reset", 64'h0, 64'($sampled(quiet_bits)));
    a_cpu_period: assert property (@(posedge clk) disable iff (!rst_n)
        cen.cpu_cen && cpu_seen |-> cpu_gap == 8'd6)
        else show_mismatch("cpu_cen period", 64'd6, 64'($sampled(cpu_gap)));
    a_cpu_cenb: assert property (@(posedge clk) disable iff (!rst_n)
        cen.cpu_cenb && cpu_seen |-> cpu_gap == 8'd3)
        else show_mismatch("cpu_cenb offset", 64'd3, 64'($sampled(cpu_gap)));
    a_pxl2_period: assert property (@(posedge clk) disable iff (!rst_n)
        cen.pxl2_cen && pxl_seen |-> pxl_gap == 8'd6)
        else show_mismatch("pxl2_cen period", 64'd6, 64'($sampled(pxl_gap)));
    a_pxl_inside: assert property (@(posedge clk) disable iff (!rst_n)
        cen.pxl_cen |-> cen.pxl2_cen)
        else note_failure("pxl_cen came without pxl2_cen");
    a_pxl_alt: assert property (@(posedge clk) disable iff (!rst_n)
        cen.pxl2_cen && pxl_seen |-> cen.pxl_cen == !pxl_prev)
        else show_mismatch("pxl_cen", 64'(!$sampled(pxl_prev)), 64'($sampled(cen.pxl_cen)));
    a_busreq: assert property (@(posedge clk) cpu_busreq == (turbo ? 1'b0 : dma_busreq))
        else show_mismatch("cpu_busreq", 64'($sampled(turbo ? 1'b0 : dma_busreq)),
                           64'($sampled(cpu_busreq)));
    a_busack: assert property (@(posedge clk) dma_busack == (turbo ? 1'b1 : cpu_busack))
        else show_mismatch("dma_busack", 64'($sampled(turbo ? 1'b1 : cpu_busack)),
                           64'($sampled(dma_busack)));
    a_ok_pulse: assert property (@(posedge clk) disable iff (!rst_n) (ok_now & ok_prev) == 5'h0)
        else show_mismatch("ok held", 64'h0, 64'($sampled(ok_now & ok_prev)));
    a_rom_data: assert property (@(posedge clk) rsp[2].ok |->
        rsp[2].data.half[req[2].addr[0]] == sd_half(req[2].addr))
        else show_mismatch("main_rom_rsp.data", 64'(sd_half($sampled(req[2].addr))),
                           64'($sampled(rsp[2].data.half[req[2].addr[0]])));
    a_ram_data: assert property (@(posedge clk) rsp[0].ok && !req[0].wr |->
        rsp[0].data.half[req[0].addr[0]] == sd_half(req[0].addr))
        else show_mismatch("main_ram_rsp.data", 64'(sd_half($sampled(req[0].addr))),
                           64'($sampled(rsp[0].data.half[req[0].addr[0]])));
    a_dma_data: assert property (@(posedge clk) rsp[1].ok |->
        rsp[1].data.half[req[1].addr[0]] == sd_half(req[1].addr))
        else show_mismatch("vram_dma_rsp.data", 64'(sd_half($sampled(req[1].addr))),
                           64'($sampled(rsp[1].data.half[req[1].addr[0]])));
    a_ram_first: assert property (@(posedge clk) rsp[1].ok |-> ram_done)
        else note_failure("VRAM DMA got its ok before main RAM");
    a_ram_write: assert property (@(posedge clk) bank_cmd[0].wr |->
        {bank_cmd[0].addr, bank_cmd[0].din, bank_cmd[0].din_m} ==
        {req[0].addr[23:1], req[0].din, req[0].dsn})
        else show_mismatch("bank_cmd[0] addr/din/din_m",
            64'($sampled({req[0].addr[23:1], req[0].din, req[0].dsn})),
            64'($sampled({bank_cmd[0].addr, bank_cmd[0].din, bank_cmd[0].din_m})));
    a_rom0_data: assert property (@(posedge clk) rsp[3].ok |->
        rsp[3].data.full == sd_word(req[3].addr))
        else show_mismatch("rom0_rsp.data", 64'(sd_word($sampled(req[3].addr))),
                           64'($sampled(rsp[3].data.full)));
    a_rom1_data: assert property (@(posedge clk) rsp[4].ok |->
        rsp[4].data.full == sd_word(req[4].addr))
        else show_mismatch("rom1_rsp.data", 64'(sd_word($sampled(req[4].addr))),
                           64'($sampled(rsp[4].data.full)));

    initial begin
        seed = 24;
        rst_n = 1'b0;
        turbo = 1'b0;
        dma_busreq = 1'b0;
        cpu_busack = 1'b0;
        // Requests pending through reset until the SDRAM side is released
        for (int i = 0; i < 5; i++) begin
            req[i] = '0;
            req[i].cs = 1'b1;
        end
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        repeat (2) @(posedge clk);
        for (int i = 0; i < 5; i++) begin
            req[i].cs <= 1'b0;
        end

        repeat (4) begin
            do begin
                @(posedge clk);
            end while (!cen.cpu_cen);
        end
        close_test("cpu enables");
        repeat (4) begin
            do begin
                @(posedge clk);
            end while (!cen.pxl_cen);
        end
        close_test("pixel enables");

        for (int i = 0; i < 8; i++) begin
            @(posedge clk);
            {turbo, dma_busreq, cpu_busack} <= i[2:0];
        end
        repeat (2) @(posedge clk);
        close_test("bus gating");

        for (int i = 0; i < 96; i++) begin
            rnd = $random(seed);
            access(2, 1'b0, rnd[23:0], 16'h0000, 2'b00);
        end
        close_test("main rom reads");

        // Every even round is a RAM write next to the DMA read
        for (int i = 0; i < 24; i++) begin
            rnd = $random(seed);
            fork
                access(0, ~i[0], rnd[23:0], rnd[31:16], rnd[25:24]);
                access(1, 1'b0, {rnd[23:1], ~rnd[0]}, 16'h0000, 2'b00);
            join
        end
        if (!wr_seen) begin
            note_failure("No RAM write command reached bank 0");
        end
        close_test("bank 0 sharing");

        for (int i = 0; i < 48; i++) begin
            rnd = $random(seed);
            fork
                access(3, 1'b0, rnd[23:0], 16'h0000, 2'b00);
                access(4, 1'b0, rnd[31:8], 16'h0000, 2'b00);
            join
        end
        close_test("graphics rom reads");

        repeat (2) @(posedge clk);
        $display("Tests run: %0d, errors: %0d", tests_run, err_count);
        if (err_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- cps2_core.f
logic/cps2_timing_pkg.sv
logic/cps2_sdram_pkg.sv
logic/cps2_sys_ctrl.sv
logic/cps2_bank_port.sv
logic/cps2_core.sv
tests/tb_sdram_model.sv
tests/tb_cps2_core.sv

//--- Makefile
VERILATOR ?= verilator
FILELIST  ?= cps2_core.f
TB_TOP    ?= tb_cps2_core
RTL_TOP   ?= cps2_core
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?=
FAIL_MSG  := Simulation finished: FAIL
PASS_MSG  := Simulation finished: PASS

SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only --timing $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP)

$(BUILD_DIR)/V$(TB_TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary --timing --assert $(VFLAGS) -f $(FILELIST) \
		--top-module $(TB_TOP) -Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TB_TOP)
	./$(BUILD_DIR)/V$(TB_TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Failure found in $(LOG)"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "No result line in $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
